//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_apb_subsystem
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST OK

.PHONY: sim clean

# Build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+src
src/apb_pkg.sv
src/apb_if.sv
src/apb_bridge.sv
src/apb_regfile.sv
src/apb_timer.sv
src/apb_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_apb_subsystem.sv

//--- sim/tb_apb_subsystem.sv
`timescale 1ns/1ps
`include "apb_macros.svh"

module tb_apb_subsystem;

	localparam logic [31:0] RF_BASE = `APB_BASE_ADDR;
	localparam logic [31:0] TMR_BASE = `APB_BASE_ADDR + `APB_BLOCK_SIZE;
	// Last byte the bridge maps
	localparam logic [31:0] MAP_END = `APB_BASE_ADDR + 2 * `APB_BLOCK_SIZE - 1;
	localparam int WORDS = `APB_REGFILE_WORDS;

	////////////////////
	// Run length

	localparam int RF_OPS = 200;
	localparam int BAD_OPS = 28;
	localparam int READBACK_OPS = WORDS + 2;
	localparam int TIMER_OPS = 32;
	localparam int MAX_GAP = 24;
	// Worst case is a timer transfer plus one idle cycle
	localparam int XFER_CYCLES = 4;
	localparam int WORST_CYCLES = 9 + 16 + 2 * MAX_GAP
		+ XFER_CYCLES * (RF_OPS + BAD_OPS + 2 * READBACK_OPS + TIMER_OPS);
	localparam int CYCLE_LIMIT = 4 * WORST_CYCLES;

	logic clk, rst;
	logic psel, penable, pwrite;
	apb_pkg::addr_t paddr;
	apb_pkg::data_t pwdata;
	apb_pkg::strb_t pstrb;
	logic pready, pslverr, irq;
	apb_pkg::data_t prdata;

	// Reference model
	apb_pkg::data_t rf_model [WORDS];
	logic ctrl_model;
	apb_pkg::data_t compare_model;

	logic [31:0] rng_state = 32'h28a4;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int cycle_count = 0;

	tb_clock_gen u_clk (.clk(clk), .rst(rst));

	apb_subsystem dut (
		.pclk(clk), .rst(rst),
		.psel(psel), .penable(penable), .paddr(paddr), .pwrite(pwrite),
		.pwdata(pwdata), .pstrb(pstrb),
		.pready(pready), .prdata(prdata), .pslverr(pslverr), .irq(irq)
	);

	// Watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Helpers

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic apb_pkg::addr_t timer_addr(input apb_pkg::timer_reg_e sel);
		return TMR_BASE + 32'(sel);
	endfunction

	task automatic check_value(input string name, input apb_pkg::data_t got,
			input apb_pkg::data_t exp);
		checks++;
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// One full transfer, sampled a little after each falling edge
	task automatic apb_transfer(input apb_pkg::addr_t addr, input logic wr,
			input apb_pkg::data_t wdata, input apb_pkg::strb_t strb,
			output apb_pkg::data_t rdata, output logic err);
		// Setup phase
		@(negedge clk);
		psel = 1'b1;
		penable = 1'b0;
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		pstrb = strb;
		// Access phase, held until pready
		@(negedge clk);
		penable = 1'b1;
		#1;
		while (!pready) begin
			@(negedge clk);
			#1;
		end
		rdata = prdata;
		err = pslverr;
		// Idle after the completing edge
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input apb_pkg::addr_t addr, input apb_pkg::data_t data,
			input apb_pkg::strb_t strb, input logic exp_err);
		apb_pkg::data_t rdata;
		logic err;
		apb_transfer(addr, 1'b1, data, strb, rdata, err);
		check_value($sformatf("pslverr @%h", addr), err, exp_err);
	endtask

	task automatic apb_read(input apb_pkg::addr_t addr, output apb_pkg::data_t data,
			input logic exp_err);
		logic err;
		// Reads carry no strobes
		apb_transfer(addr, 1'b0, '0, '0, data, err);
		check_value($sformatf("pslverr @%h", addr), err, exp_err);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Read back every modelled register
	task automatic check_state();
		apb_pkg::data_t data;
		for (int i = 0; i < WORDS; i++) begin
			apb_read(RF_BASE + 4 * i, data, 1'b0);
			check_value($sformatf("prdata rf[%0d]", i), data, rf_model[i]);
		end
		apb_read(timer_addr(apb_pkg::timer_ctrl), data, 1'b0);
		check_value("prdata ctrl", data, {31'b0, ctrl_model});
		apb_read(timer_addr(apb_pkg::timer_compare), data, 1'b0);
		check_value("prdata compare", data, compare_model);
	endtask

	task automatic end_test(input string name, input int start);
		tests++;
		$display("%-18s %s, %0d errors", name, (errors == start) ? "passed" : "failed",
			errors - start);
	endtask

	////////////////////
	// Tests

	initial begin
		int start;
		int idx;
		int gap;
		logic [31:0] r;
		apb_pkg::addr_t addr;
		apb_pkg::data_t data, prev;
		apb_pkg::strb_t strb;
		psel = 1'b0;
		penable = 1'b0;
		paddr = '0;
		pwrite = 1'b0;
		pwdata = '0;
		pstrb = '0;
		for (int i = 0; i < WORDS; i++) begin
			rf_model[i] = '0;
		end
		ctrl_model = 1'b0;
		compare_model = '0;
		wait (rst === 1'b0);

		// Random register-file traffic, strobes applied per byte in the model
		start = errors;
		for (int i = 0; i < RF_OPS; i++) begin
			r = next_rand();
			idx = int'(r[15:0]) % WORDS;
			if (r[16]) begin
				data = next_rand();
				strb = apb_pkg::strb_t'(next_rand());
				apb_write(RF_BASE + 4 * idx, data, strb, 1'b0);
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						rf_model[idx][8*b +: 8] = data[8*b +: 8];
					end
				end
			end else begin
				apb_read(RF_BASE + 4 * idx, data, 1'b0);
				check_value($sformatf("prdata rf[%0d]", idx), data, rf_model[idx]);
			end
		end
		end_test("regfile_random", start);

		// Unmapped addresses, just above, just below or anywhere
		start = errors;
		for (int i = 0; i < 20; i++) begin
			do begin
				r = next_rand();
				case (r[1:0])
					2'd0: addr = MAP_END + 1 + (next_rand() & 32'h0000_fffc);
					2'd1: addr = RF_BASE - 4 - (next_rand() & 32'h0000_fffc);
					default: addr = next_rand();
				endcase
			end while (addr >= RF_BASE && addr <= MAP_END);
			if (r[2]) begin
				apb_write(addr, next_rand(), 4'hf, 1'b1);
			end else begin
				apb_read(addr, data, 1'b1);
			end
		end
		check_state();
		// Aligned register-file offsets from 0x10 up to the block end
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			addr = RF_BASE + 16 + ((r % (`APB_BLOCK_SIZE - 16)) & ~32'h3);
			if (r[31]) begin
				apb_write(addr, next_rand(), 4'hf, 1'b1);
			end else begin
				apb_read(addr, data, 1'b1);
			end
		end
		check_state();
		end_test("decode_errors", start);

		// Timer register access
		start = errors;
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h1, 4'hf, 1'b0);
		apb_read(timer_addr(apb_pkg::timer_ctrl), data, 1'b0);
		check_value("prdata ctrl", data, 32'h1);
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h0, 4'hf, 1'b0);
		apb_read(timer_addr(apb_pkg::timer_ctrl), data, 1'b0);
		check_value("prdata ctrl", data, 32'h0);
		compare_model = next_rand();
		apb_write(timer_addr(apb_pkg::timer_compare), compare_model, 4'hf, 1'b0);
		apb_read(timer_addr(apb_pkg::timer_compare), data, 1'b0);
		check_value("prdata compare", data, compare_model);
		// Stopped counter holds its value
		prev = next_rand();
		apb_write(timer_addr(apb_pkg::timer_count), prev, 4'hf, 1'b0);
		apb_read(timer_addr(apb_pkg::timer_count), data, 1'b0);
		check_value("prdata count", data, prev);
		idle_cycles(5);
		apb_read(timer_addr(apb_pkg::timer_count), data, 1'b0);
		check_value("prdata count", data, prev);
		// Strobe between 1 and 14
		strb = apb_pkg::strb_t'(next_rand() % 14 + 1);
		apb_write(timer_addr(apb_pkg::timer_compare), ~compare_model, strb, 1'b1);
		apb_read(timer_addr(apb_pkg::timer_compare), data, 1'b0);
		check_value("prdata compare", data, compare_model);
		end_test("timer_access", start);

		// Counting, compare kept below the start so no match
		start = errors;
		compare_model = '0;
		apb_write(timer_addr(apb_pkg::timer_compare), 32'h0, 4'hf, 1'b0);
		apb_write(timer_addr(apb_pkg::timer_count), 32'h100, 4'hf, 1'b0);
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h1, 4'hf, 1'b0);
		ctrl_model = 1'b1;
		apb_read(timer_addr(apb_pkg::timer_count), prev, 1'b0);
		for (int i = 0; i < 5; i++) begin
			apb_read(timer_addr(apb_pkg::timer_count), data, 1'b0);
			checks++;
			assert (data > prev) else begin
				$display("Mismatch at %0t: count got %h expected above %h", $time, data, prev);
				errors++;
			end
			prev = data;
		end
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h0, 4'hf, 1'b0);
		ctrl_model = 1'b0;
		apb_read(timer_addr(apb_pkg::timer_count), prev, 1'b0);
		idle_cycles(3);
		apb_read(timer_addr(apb_pkg::timer_count), data, 1'b0);
		check_value("prdata count", data, prev);
		end_test("timer_counting", start);

		// Compare match a few cycles ahead of the count
		start = errors;
		gap = 5 + int'(next_rand() % (MAX_GAP - 4));
		data = next_rand() & 32'h0fff_ffff;
		compare_model = data + gap;
		apb_write(timer_addr(apb_pkg::timer_compare), compare_model, 4'hf, 1'b0);
		apb_write(timer_addr(apb_pkg::timer_count), data, 4'hf, 1'b0);
		apb_write(timer_addr(apb_pkg::timer_status), 32'h1, 4'hf, 1'b0);
		#1;
		check_value("irq", irq, 32'h0);
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h1, 4'hf, 1'b0);
		ctrl_model = 1'b1;
		idx = 0;
		while (!irq && idx < 2 * gap) begin
			@(negedge clk);
			idx++;
		end
		checks++;
		assert (irq) else begin
			$display("Error at %0t: irq did not rise within %0d cycles", $time, 2 * gap);
			errors++;
		end
		apb_read(timer_addr(apb_pkg::timer_status), data, 1'b0);
		check_value("prdata status", data, 32'h1);
		// Write one to clear
		apb_write(timer_addr(apb_pkg::timer_status), 32'h1, 4'hf, 1'b0);
		apb_read(timer_addr(apb_pkg::timer_status), data, 1'b0);
		check_value("prdata status", data, 32'h0);
		#1;
		check_value("irq", irq, 32'h0);
		apb_write(timer_addr(apb_pkg::timer_ctrl), 32'h0, 4'hf, 1'b0);
		ctrl_model = 1'b0;
		end_test("timer_match_irq", start);

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

// Clock and power-on reset for the testbench
module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD_NS) clk = ~clk;
	end

	// Reset spans eight rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- src/apb_bridge.sv
`timescale 1ns/1ps
`include "apb_macros.svh"

// Combinational one-to-many APB bridge
// Each port owns one equal block of address space starting at the base
module apb_bridge #(
	parameter int NUM_PORTS = 2
) (
	apb_if.completer upstream,
	apb_if.requester downstream [NUM_PORTS-1:0]
);

	// Offset bits inside one block
	localparam int BLOCK_BITS = $clog2(`APB_BLOCK_SIZE);
	// Address bits above the block offset
	localparam int DEVICE_BITS = `APB_ADDR_WIDTH - BLOCK_BITS;
	// Port index bits, at least one so the slices stay legal
	localparam int INDEX_BITS = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	// Block number of the base address
	localparam logic [DEVICE_BITS-1:0] BASE_BLOCK = DEVICE_BITS'(`APB_BASE_ADDR >> BLOCK_BITS);

	////////////////////
	// Request fan-out

	// Everything except psel goes to all ports unchanged
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_fanout
		assign downstream[g].penable = upstream.penable;
		assign downstream[g].pwrite  = upstream.pwrite;
		assign downstream[g].pwdata  = upstream.pwdata;
		assign downstream[g].pstrb   = upstream.pstrb;
		// Completers only see the offset within their block
		assign downstream[g].paddr   = {{DEVICE_BITS{1'b0}}, upstream.paddr[BLOCK_BITS-1:0]};
	end

	////////////////////
	// Address decode

	logic [DEVICE_BITS-1:0] block_addr;
	logic [INDEX_BITS-1:0]  devid;
	logic                   range_hit;
	logic                   port_hit;

	always_comb begin
		block_addr = upstream.paddr[`APB_ADDR_WIDTH-1:BLOCK_BITS];
		// Upper bits must match the base block
		range_hit = (block_addr[DEVICE_BITS-1:INDEX_BITS] == BASE_BLOCK[DEVICE_BITS-1:INDEX_BITS]);
		// Low block bits pick the port
		devid = block_addr[INDEX_BITS-1:0];
		// Index may exceed the port count when NUM_PORTS is not a power of two
		port_hit = range_hit && (int'(devid) < NUM_PORTS);
	end

	// Only the addressed port is selected
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_sel
		assign downstream[g].psel = upstream.psel && port_hit && (int'(devid) == g);
	end

	////////////////////
	// Reply collection

	// Plain vectors so the mux can index with a variable
	logic [NUM_PORTS-1:0] pready_v;
	logic [NUM_PORTS-1:0] pslverr_v;
	apb_pkg::data_t       prdata_v [NUM_PORTS];

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_reply
		assign pready_v[g]  = downstream[g].pready;
		assign pslverr_v[g] = downstream[g].pslverr;
		assign prdata_v[g]  = downstream[g].prdata;
	end

	////////////////////
	// Reply mux

	always_comb begin
		// Idle defaults
		upstream.pready  = 1'b0;
		upstream.prdata  = '0;
		upstream.pslverr = 1'b0;
		if (upstream.psel) begin
			if (port_hit) begin
				// Forward from the selected port
				upstream.pready  = pready_v[devid];
				upstream.prdata  = prdata_v[devid];
				upstream.pslverr = pslverr_v[devid];
			end else begin
				// Unmapped address, answer here with an error
				upstream.pready  = 1'b1;
				upstream.pslverr = 1'b1;
			end
		end
	end

endmodule

//--- src/apb_if.sv
`timescale 1ns/1ps

interface apb_if;

	////////////////////
	// Request side

	// Select and enable give the setup and access phases
	logic psel;
	logic penable;

	// Address, direction and write payload
	apb_pkg::addr_t paddr;
	logic pwrite;
	apb_pkg::data_t pwdata;
	apb_pkg::strb_t pstrb;

	////////////////////
	// Reply side

	// Completion and read payload
	logic pready;
	apb_pkg::data_t prdata;

	// Error flag, sampled on the completing edge only
	logic pslverr;

	// Peripheral end of the link
	modport completer (
		input psel, penable, paddr, pwrite, pwdata, pstrb,
		output pready, prdata, pslverr
	);

	// Initiator end of the link
	modport requester (
		output psel, penable, paddr, pwrite, pwdata, pstrb,
		input pready, prdata, pslverr
	);

endinterface

//--- src/apb_macros.svh
`ifndef APB_MACROS_SVH
`define APB_MACROS_SVH

// Bus geometry shared by every block on the peripheral bus

// Address and data widths in bits
`define APB_ADDR_WIDTH 32
`define APB_DATA_WIDTH 32

// Bridge address map
// Completer n sits at APB_BASE_ADDR + n * APB_BLOCK_SIZE
`define APB_BASE_ADDR 32'h4000_0000

// Bytes of address space per completer
// Must be a power of two
`define APB_BLOCK_SIZE 32'h0000_0800

// Register file depth in 32-bit words
`define APB_REGFILE_WORDS 4

`endif

//--- src/apb_pkg.sv
`include "apb_macros.svh"

package apb_pkg;

	////////////////////
	// Bus word types

	// Byte address as seen on paddr
	typedef logic [`APB_ADDR_WIDTH-1:0] addr_t;

	// Read and write data word
	typedef logic [`APB_DATA_WIDTH-1:0] data_t;

	// One write strobe per data byte
	typedef logic [`APB_DATA_WIDTH/8-1:0] strb_t;

	////////////////////
	// Timer register map

	// Byte offsets within the timer block
	// Status bit 0 is the sticky match flag, write 1 to clear
	typedef enum logic [3:0] {
		timer_ctrl    = 4'h0,
		timer_count   = 4'h4,
		timer_compare = 4'h8,
		timer_status  = 4'hC
	} timer_reg_e;

endpackage

//--- src/apb_regfile.sv
`timescale 1ns/1ps
`include "apb_macros.svh"

// Bank of read/write words with byte write strobes
// Zero wait states so pready is high in the first access cycle
module apb_regfile #(
	parameter int WORDS = `APB_REGFILE_WORDS
) (
	input logic pclk,
	input logic rst,
	apb_if.completer bus
);

	// At least one index bit into the bank
	localparam int IDX_BITS = (WORDS > 1) ? $clog2(WORDS) : 1;
	// Bytes per data word
	localparam int NUM_BYTES = `APB_DATA_WIDTH / 8;

	////////////////////
	// Offset decode

	// Word number from the full byte offset
	logic [`APB_ADDR_WIDTH-3:0] word_addr;
	logic [IDX_BITS-1:0]        word_idx;
	logic                       addr_ok;

	// Access phase of a selected transfer
	// Every access cycle is also the completing one
	logic access;

	always_comb begin
		word_addr = bus.paddr[`APB_ADDR_WIDTH-1:2];
		word_idx  = word_addr[IDX_BITS-1:0];
		// Must be word aligned and inside the bank
		addr_ok = (bus.paddr[1:0] == 2'b00) && (word_addr < WORDS);
	end

	assign access = bus.psel && bus.penable;

	////////////////////
	// Storage

	apb_pkg::data_t regs [WORDS];

	always_ff @(posedge pclk) begin
		if (rst) begin
			// All words read back as zero after reset
			for (int i = 0; i < WORDS; i++) begin
				regs[i] <= '0;
			end
		end else if (access && bus.pwrite && addr_ok) begin
			// Update only strobed bytes
			for (int b = 0; b < NUM_BYTES; b++) begin
				if (bus.pstrb[b]) begin
					regs[word_idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
				end
			end
		end
	end

	////////////////////
	// Reply

	// No wait states
	assign bus.pready = access;

	// Bad offsets complete with an error and leave the bank alone
	assign bus.pslverr = access && !addr_ok;

	// Read data for the addressed word
	always_comb begin
		bus.prdata = '0;
		if (addr_ok) begin
			bus.prdata = regs[word_idx];
		end
	end

endmodule

//--- src/apb_subsystem.sv
`timescale 1ns/1ps

// APB peripheral subsystem
// Bridge at the base address, register file on port 0, timer on port 1
module apb_subsystem (
	input logic pclk,
	input logic rst,

	// Upstream APB requester
	input logic psel,
	input logic penable,
	input apb_pkg::addr_t paddr,
	input logic pwrite,
	input apb_pkg::data_t pwdata,
	input apb_pkg::strb_t pstrb,
	output logic pready,
	output apb_pkg::data_t prdata,
	output logic pslverr,

	// Timer interrupt
	output logic irq
);

	// One upstream link and one link per completer
	apb_if up_bus ();
	apb_if dn_bus [1:0] ();

	////////////////////
	// Top-level ports onto the upstream link

	// Request from the external requester
	assign up_bus.psel    = psel;
	assign up_bus.penable = penable;
	assign up_bus.paddr   = paddr;
	assign up_bus.pwrite  = pwrite;
	assign up_bus.pwdata  = pwdata;
	assign up_bus.pstrb   = pstrb;

	// Reply back out
	assign pready  = up_bus.pready;
	assign prdata  = up_bus.prdata;
	assign pslverr = up_bus.pslverr;

	////////////////////
	// Bridge and completers

	// Two equal blocks from the base address
	apb_bridge #(
		.NUM_PORTS(2)
	) u_bridge (
		.upstream  (up_bus.completer),
		.downstream(dn_bus)
	);

	// Port 0 at offset 0x000
	apb_regfile u_regfile (
		.pclk(pclk),
		.rst (rst),
		.bus (dn_bus[0])
	);

	// Port 1 at offset 0x800
	apb_timer u_timer (
		.pclk(pclk),
		.rst (rst),
		.bus (dn_bus[1]),
		.irq (irq)
	);

endmodule

//--- src/apb_timer.sv
`timescale 1ns/1ps
`include "apb_macros.svh"

// Free-running timer with compare match and interrupt
// Exactly one wait state on every transfer
module apb_timer (
	input logic pclk,
	input logic rst,
	apb_if.completer bus,
	output logic irq
);

	////////////////////
	// Handshake

	// Access phase of a selected transfer
	logic access;
	// High in the second access cycle
	logic wait_st;
	// Transfer completes on this edge
	logic done;

	assign access = bus.psel && bus.penable;
	assign done   = access && wait_st;

	// Set after the first access cycle, cleared once the transfer ends
	always_ff @(posedge pclk) begin
		if (rst) begin
			wait_st <= 1'b0;
		end else begin
			wait_st <= access && !wait_st;
		end
	end

	////////////////////
	// Register decode

	apb_pkg::timer_reg_e reg_sel;
	// Offset names one of the four registers
	logic reg_ok;
	// Write uses every byte lane
	logic full_strb;
	// Write that is allowed to change state
	logic wr_ok;

	always_comb begin
		reg_sel   = apb_pkg::timer_reg_e'(bus.paddr[3:0]);
		// Aligned offsets below 0x10 are exactly the known registers
		reg_ok    = (bus.paddr[`APB_ADDR_WIDTH-1:4] == '0) && (bus.paddr[1:0] == 2'b00);
		full_strb = (bus.pstrb == '1);
		wr_ok     = done && bus.pwrite && reg_ok && full_strb;
	end

	////////////////////
	// Timer state

	logic ctrl_en;
	apb_pkg::data_t count;
	apb_pkg::data_t compare;
	logic match;

	// Match condition and write-1-to-clear request
	logic match_set;
	logic match_clr;

	assign match_set = ctrl_en && (count == compare);
	assign match_clr = wr_ok && (reg_sel == apb_pkg::timer_status) && bus.pwdata[0];

	always_ff @(posedge pclk) begin
		if (rst) begin
			ctrl_en <= 1'b0;
			count   <= '0;
			compare <= '0;
			match   <= 1'b0;
		end else begin
			// Counting, overridden below by a count write
			if (ctrl_en) begin
				count <= count + 1'b1;
			end
			if (wr_ok) begin
				case (reg_sel)
					apb_pkg::timer_ctrl:    ctrl_en <= bus.pwdata[0];
					apb_pkg::timer_count:   count   <= bus.pwdata;
					apb_pkg::timer_compare: compare <= bus.pwdata;
					default: ;
				endcase
			end
			// New match wins over a clear in the same cycle
			match <= match_set || (match && !match_clr);
		end
	end

	// Interrupt follows the sticky flag
	assign irq = match;

	////////////////////
	// Reply

	assign bus.pready = wait_st;

	// Unknown offset, or a write with a partial strobe
	assign bus.pslverr = wait_st && (!reg_ok || (bus.pwrite && !full_strb));

	always_comb begin
		bus.prdata = '0;
		if (reg_ok) begin
			case (reg_sel)
				apb_pkg::timer_ctrl:    bus.prdata[0] = ctrl_en;
				apb_pkg::timer_count:   bus.prdata    = count;
				apb_pkg::timer_compare: bus.prdata    = compare;
				apb_pkg::timer_status:  bus.prdata[0] = match;
				default: ;
			endcase
		end
	end

endmodule
